// ==== llr_demap_top.f ====
+incdir+hdl
hdl/llr_demap_pkg.sv
hdl/llr_mode_regs.sv
hdl/llr_psk_demapper.sv
hdl/llr_qam16_demapper.sv
hdl/llr_output_select.sv
hdl/llr_demap_top.sv
verif/llr_demap_tb.sv

// ==== Bender.yml ====
package:
  name: llr_demap

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/llr_demap_pkg.sv
      - hdl/llr_mode_regs.sv
      - hdl/llr_psk_demapper.sv
      - hdl/llr_qam16_demapper.sv
      - hdl/llr_output_select.sv
      - hdl/llr_demap_top.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - verif/llr_demap_tb.sv

// ==== verif/llr_demap_tb.sv ====
`timescale 1ns/100ps
`include "llr_demap_settings.svh"

module llr_demap_tb;

  localparam int llr_w      = `LLR_LLR_W;
  localparam int dat_w      = `LLR_DAT_W;
  localparam int frame_len  = 24;
  localparam int ext_len    = 9;
  localparam int toggle_len = 32;
  // seven plain frames, four full scale frames, two gapped frames
  localparam int sample_total = 7 * frame_len + 4 * ext_len + 2 * toggle_len;
  // gapped samples average two cycles so four per sample leaves room
  localparam int cycle_limit  = 4 * sample_total + 300;

  typedef struct packed {
    logic               sop;
    logic [3:0]         qam;
    logic [4*llr_w-1:0] llr;
  } expect_t;

  logic                     iclk;
  logic                     ireset;
  logic                     iclkena;
  logic                     cfg_write;
  llr_demap_pkg::qam_code_t cfg_qam;
  logic                     ival;
  logic                     isop;
  llr_demap_pkg::sample_t   idat;
  logic                     oval;
  logic                     osop;
  llr_demap_pkg::qam_code_t oqam;
  llr_demap_pkg::llr_word_t ollr;

  int         seed = 56;
  int         errors = 0;
  int         cycles = 0;
  int         ena_cnt = 0;
  logic       ena_q = 1'b0;
  expect_t    exp_q[$];
  int         take_q[$];
  // model copy of the code registers
  logic [3:0] staged_code = 4'd1;
  logic [3:0] active_code = 4'd1;
  expect_t    got_exp;
  int         take_idx;

  llr_demap_top dut0 (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .cfg_write (cfg_write),
    .cfg_qam   (cfg_qam),
    .ival      (ival),
    .isop      (isop),
    .idat      (idat),
    .oval      (oval),
    .osop      (osop),
    .oqam      (oqam),
    .ollr      (ollr)
  );

  initial begin
    iclk = 1'b0;
    forever #4 iclk = ~iclk;
  end

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------

  // clip to the signed llr range
  function automatic logic [llr_w-1:0] clip(input int v);
    int hi;
    int lo;
    int c;
    hi = (1 << (llr_w - 1)) - 1;
    lo = -(1 << (llr_w - 1));
    c = (v > hi) ? hi : ((v < lo) ? lo : v);
    return c[llr_w-1:0];
  endfunction

  function automatic int mag(input int v);
    return (v < 0) ? -v : v;
  endfunction

  // unknown codes fall back to bpsk
  function automatic logic [3:0] legal_code(input logic [3:0] code);
    return (code >= 4'd1 && code <= 4'd4) ? code : 4'd1;
  endfunction

  function automatic logic [4*llr_w-1:0] rule_llr(input logic [3:0] code,
                                                  input logic signed [dat_w-1:0] re,
                                                  input logic signed [dat_w-1:0] im);
    int               r;
    int               i;
    logic [llr_w-1:0] b3;
    logic [llr_w-1:0] b2;
    logic [llr_w-1:0] b1;
    logic [llr_w-1:0] b0;
    r = re;
    i = im;
    if (code == 4'd4) begin
      b3 = clip(r);
      b2 = clip(i);
      b1 = clip(`LLR_QAM16_THR - mag(r));
      b0 = clip(`LLR_QAM16_THR - mag(i));
    end else begin
      // lanes the constellation lacks read as zero
      b3 = '0;
      b2 = (code == 4'd3) ? clip(i) : '0;
      b1 = (code == 4'd2 || code == 4'd3) ? clip(r) : '0;
      b0 = code[1] ? clip(mag(r) - mag(i)) : clip(r + i);
    end
    return {b3, b2, b1, b0};
  endfunction

  // ----------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------

  // one clock of inputs and the model update for what the dut will take
  task automatic cycle(input logic ena, input logic wr, input logic [3:0] code,
                       input logic v, input logic sop,
                       input logic [dat_w-1:0] re, input logic [dat_w-1:0] im);
    expect_t    e;
    logic [3:0] use_code;
    @(posedge iclk);
    iclkena   <= ena;
    cfg_write <= wr;
    cfg_qam   <= code;
    ival      <= v;
    isop      <= sop;
    idat.re   <= re;
    idat.im   <= im;
    if (ena) begin
      if (v) begin
        // sop sample already sees the staged code
        use_code = sop ? staged_code : active_code;
        if (sop) begin
          active_code = staged_code;
        end
        e.sop = sop;
        e.qam = use_code;
        e.llr = rule_llr(use_code, re, im);
        exp_q.push_back(e);
      end
      if (wr) begin
        staged_code = legal_code(code);
      end
    end
  endtask

  task automatic idle();
    cycle(1'b1, 1'b0, 4'd0, 1'b0, 1'b0, '0, '0);
  endtask

  // kind 0 full range, 1 near the ring boundary, 2 full scale corners
  function automatic logic [dat_w-1:0] pick_comp(input int kind, input int idx);
    int r;
    r = $random(seed);
    if (kind == 1) begin
      return dat_w'(r % 9);
    end
    if (kind == 2) begin
      case (idx % 3)
        0:       return {1'b0, {(dat_w-1){1'b1}}};
        1:       return {1'b1, {(dat_w-1){1'b0}}};
        default: return {1'b1, {(dat_w-2){1'b0}}, 1'b1};
      endcase
    end
    return r[dat_w-1:0];
  endfunction

  // mode 0 keeps the staged code and wr_at picks a mid frame write
  task automatic send_frame(input logic [3:0] mode, input int len, input int kind,
                            input bit toggle, input int wr_at, input logic [3:0] wr_code);
    logic [dat_w-1:0] re;
    logic [dat_w-1:0] im;
    int               r;
    if (mode != 4'd0) begin
      cycle(1'b1, 1'b1, mode, 1'b0, 1'b0, '0, '0);
    end
    for (int i = 0; i < len; i++) begin
      re = pick_comp(kind, i);
      im = pick_comp(kind, i / 3);
      r = $random(seed);
      // sample held while the enable is low
      while (toggle && r[0]) begin
        cycle(1'b0, 1'b0, wr_code, 1'b1, i == 0, re, im);
        r = $random(seed);
      end
      cycle(1'b1, i == wr_at, wr_code, 1'b1, i == 0, re, im);
    end
  endtask

  initial begin
    iclkena   = 1'b1;
    cfg_write = 1'b0;
    cfg_qam   = 4'd1;
    ival      = 1'b0;
    isop      = 1'b0;
    idat      = '0;
    ireset    = 1'b1;
    repeat (4) @(posedge iclk);
    ireset <= 1'b0;
    // oval has to stay low over a quiet stretch
    repeat (6) idle();
    // psk frames of random samples
    send_frame(4'd1, frame_len, 0, 1'b0, -1, 4'd0);
    send_frame(4'd2, frame_len, 0, 1'b0, -1, 4'd0);
    send_frame(4'd3, frame_len, 0, 1'b0, -1, 4'd0);
    // 16qam around the ring boundary
    send_frame(4'd4, frame_len, 1, 1'b0, -1, 4'd0);
    // full scale corners on every code
    for (int m = 1; m <= 4; m++) begin
      send_frame(m[3:0], ext_len, 2, 1'b0, -1, 4'd0);
    end
    // writes mid frame wait for the next sop and 4'hb lands as bpsk
    send_frame(4'd2, frame_len, 0, 1'b0, frame_len / 2, 4'd4);
    send_frame(4'd0, frame_len, 1, 1'b0, frame_len / 2, 4'hb);
    send_frame(4'd0, frame_len, 0, 1'b0, -1, 4'd0);
    // random enable gaps
    send_frame(4'd3, toggle_len, 0, 1'b1, -1, 4'd0);
    send_frame(4'd4, toggle_len, 1, 1'b1, -1, 4'd0);
    // flush the pipeline
    for (int k = 0; k < 20 && exp_q.size() != 0; k++) begin
      idle();
    end
    repeat (8) idle();
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("%0d expected results never came out of the DUT", exp_q.size());
    end
    $display("run ended with %0d errors", errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------

  // outputs read before this edge and gated by the enable of the edge before
  always @(posedge iclk) begin
    if (!ireset) begin
      if (ena_q && oval) begin
        assert (exp_q.size() != 0 && take_q.size() != 0) else begin
          errors++;
          $display("oval was high with no sample in flight");
        end
        if (exp_q.size() != 0 && take_q.size() != 0) begin
          got_exp = exp_q.pop_front();
          take_idx = take_q.pop_front();
          assert (ena_cnt - take_idx == 5) else begin
            errors++;
            $display("oval came %0d cycles after ival instead of 6", ena_cnt - take_idx + 1);
          end
          assert (osop === got_exp.sop) else begin
            errors++;
            $display("Error: osop got %h expected %h", osop, got_exp.sop);
          end
          assert (oqam === got_exp.qam) else begin
            errors++;
            $display("Error: oqam got %h expected %h", oqam, got_exp.qam);
          end
          assert (ollr === got_exp.llr) else begin
            errors++;
            $display("Error: ollr got %h expected %h", ollr, got_exp.llr);
          end
        end
      end
      // index of every enabled edge that takes a sample
      if (iclkena) begin
        ena_cnt++;
        if (ival) begin
          take_q.push_back(ena_cnt);
        end
      end
      ena_q = iclkena;
    end
  end

  // watchdog
  always @(posedge iclk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("run did not finish within %0d cycles", cycle_limit);
      $display("run ended with %0d errors", errors);
      $display("Verification failed");
      $finish;
    end
  end

endmodule

// ==== hdl/llr_demap_top.sv ====
`timescale 1ns/100ps

module llr_demap_top (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     iclkena,
  input  logic                     cfg_write,
  input  llr_demap_pkg::qam_code_t cfg_qam,
  input  logic                     ival,
  input  logic                     isop,
  input  llr_demap_pkg::sample_t   idat,
  output logic                     oval,
  output logic                     osop,
  output llr_demap_pkg::qam_code_t oqam,
  output llr_demap_pkg::llr_word_t ollr
);

  // ----------------------------------------------------------
  // internal wires
  // ----------------------------------------------------------

  // code in force for the incoming sample
  llr_demap_pkg::stage_ctl_t ctl;

  // psk result with its valid and control
  logic                      psk_val;
  llr_demap_pkg::stage_ctl_t psk_ctl;
  llr_demap_pkg::llr_word_t  psk_llr;

  // 16qam lanes, timing taken from the psk side
  llr_demap_pkg::llr_word_t  q16_llr;

  // ----------------------------------------------------------
  // instances
  // ----------------------------------------------------------

  llr_mode_regs mode_regs0 (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .cfg_write (cfg_write),
    .cfg_qam   (cfg_qam),
    .ival      (ival),
    .isop      (isop),
    .ctl       (ctl)
  );

  llr_psk_demapper psk0 (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ival    (ival),
    .ictl    (ctl),
    .idat    (idat),
    .oval    (psk_val),
    .octl    (psk_ctl),
    .ollr    (psk_llr)
  );

  // valid and control of this path mirror the psk path
  llr_qam16_demapper q16_0 (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ival    (ival),
    .ictl    (ctl),
    .idat    (idat),
    .oval    (),
    .octl    (),
    .ollr    (q16_llr)
  );

  llr_output_select out_sel0 (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .psk_val (psk_val),
    .psk_ctl (psk_ctl),
    .psk_llr (psk_llr),
    .q16_llr (q16_llr),
    .oval    (oval),
    .osop    (osop),
    .oqam    (oqam),
    .ollr    (ollr)
  );

endmodule

// ==== hdl/llr_output_select.sv ====
`timescale 1ns/100ps

module llr_output_select (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      iclkena,
  input  logic                      psk_val,
  input  llr_demap_pkg::stage_ctl_t psk_ctl,
  input  llr_demap_pkg::llr_word_t  psk_llr,
  input  llr_demap_pkg::llr_word_t  q16_llr,
  output logic                      oval,
  output logic                      osop,
  output llr_demap_pkg::qam_code_t  oqam,
  output llr_demap_pkg::llr_word_t  ollr
);

  llr_demap_pkg::llr_word_t sel_llr;

  // ----------------------------------------------------------
  // lane select and mask
  // ----------------------------------------------------------

  // both paths aligned, psk control speaks for both
  always_comb begin
    sel_llr = psk_llr;
    case (psk_ctl.qam)
      llr_demap_pkg::qam_qam16: begin
        sel_llr = q16_llr;
      end
      llr_demap_pkg::qam_8psk: begin
        sel_llr.b3 = '0;
      end
      llr_demap_pkg::qam_qpsk: begin
        sel_llr.b3 = '0;
        sel_llr.b2 = '0;
      end
      // bpsk and anything unknown, b0 only
      default: begin
        sel_llr.b3 = '0;
        sel_llr.b2 = '0;
        sel_llr.b1 = '0;
      end
    endcase
  end

  // ----------------------------------------------------------
  // output register
  // ----------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end else if (iclkena) begin
      oval <= psk_val;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && psk_val) begin
      osop <= psk_ctl.sop;
      oqam <= psk_ctl.qam;
      ollr <= sel_llr;
    end
  end

endmodule

// ==== hdl/llr_qam16_demapper.sv ====
`timescale 1ns/100ps
`include "llr_demap_settings.svh"

module llr_qam16_demapper (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      iclkena,
  input  logic                      ival,
  input  llr_demap_pkg::stage_ctl_t ictl,
  input  llr_demap_pkg::sample_t    idat,
  output logic                      oval,
  output llr_demap_pkg::stage_ctl_t octl,
  output llr_demap_pkg::llr_word_t  ollr
);

  // inner/outer boundary in the widened domain
  localparam llr_demap_pkg::wide_t thr = llr_demap_pkg::wide_t'(`LLR_QAM16_THR);

  // ----------------------------------------------------------
  // pipeline state
  // ----------------------------------------------------------

  // same depth as the psk path
  logic [3:0]                val;
  llr_demap_pkg::stage_ctl_t ctl [4];

  // stage 1
  llr_demap_pkg::wide_t      dat_re;
  llr_demap_pkg::wide_t      dat_im;
  llr_demap_pkg::wide_t      adat_re;
  llr_demap_pkg::wide_t      adat_im;

  // stage 2, sign metrics and distance to boundary
  llr_demap_pkg::wide_t      b3_met;
  llr_demap_pkg::wide_t      b2_met;
  llr_demap_pkg::wide_t      b1_met;
  llr_demap_pkg::wide_t      b0_met;

  // stage 3 and 4
  llr_demap_pkg::llr_word_t  sat_llr;
  llr_demap_pkg::llr_word_t  dly_llr;

  // ----------------------------------------------------------
  // valid chain
  // ----------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val  <= '0;
      oval <= 1'b0;
    end else if (iclkena) begin
      val  <= {val[2:0], ival};
      oval <= val[3];
    end
  end

  // ----------------------------------------------------------
  // data path
  // ----------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      ctl[0] <= ictl;
      for (int i = 1; i < 4; i++) begin
        ctl[i] <= ctl[i-1];
      end
      // stage 1
      dat_re  <= llr_demap_pkg::widen(idat.re);
      dat_im  <= llr_demap_pkg::widen(idat.im);
      adat_re <= llr_demap_pkg::abs_wide(llr_demap_pkg::widen(idat.re));
      adat_im <= llr_demap_pkg::abs_wide(llr_demap_pkg::widen(idat.im));
      // stage 2
      // msbs by sign, lsbs by inner vs outer ring
      b3_met <= dat_re;
      b2_met <= dat_im;
      b1_met <= thr - adat_re;
      b0_met <= thr - adat_im;
      // stage 3
      sat_llr.b3 <= llr_demap_pkg::saturate_llr(b3_met);
      sat_llr.b2 <= llr_demap_pkg::saturate_llr(b2_met);
      sat_llr.b1 <= llr_demap_pkg::saturate_llr(b1_met);
      sat_llr.b0 <= llr_demap_pkg::saturate_llr(b0_met);
      // stage 4
      dly_llr <= sat_llr;
      // stage 5
      if (val[3]) begin
        octl <= ctl[3];
        ollr <= dly_llr;
      end
    end
  end

endmodule

// ==== hdl/llr_psk_demapper.sv ====
`timescale 1ns/100ps

module llr_psk_demapper (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      iclkena,
  input  logic                      ival,
  input  llr_demap_pkg::stage_ctl_t ictl,
  input  llr_demap_pkg::sample_t    idat,
  output logic                      oval,
  output llr_demap_pkg::stage_ctl_t octl,
  output llr_demap_pkg::llr_word_t  ollr
);

  // ----------------------------------------------------------
  // pipeline state
  // ----------------------------------------------------------

  // valid per stage, bit 3 feeds the capture stage
  logic [3:0]                val;
  llr_demap_pkg::stage_ctl_t ctl [4];

  // stage 1, registered components and magnitudes
  llr_demap_pkg::wide_t      dat_re;
  llr_demap_pkg::wide_t      dat_im;
  llr_demap_pkg::wide_t      adat_re;
  llr_demap_pkg::wide_t      adat_im;

  // stage 2, raw metrics
  llr_demap_pkg::wide_t      b0_met;
  llr_demap_pkg::wide_t      b1_met;
  llr_demap_pkg::wide_t      b2_met;

  // stage 3 clipped, stage 4 delayed
  llr_demap_pkg::llr_word_t  sat_llr;
  llr_demap_pkg::llr_word_t  dly_llr;

  // ----------------------------------------------------------
  // valid chain
  // ----------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val  <= '0;
      oval <= 1'b0;
    end else if (iclkena) begin
      val  <= {val[2:0], ival};
      oval <= val[3];
    end
  end

  // ----------------------------------------------------------
  // data path
  // ----------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      // control follows the data stage by stage
      ctl[0] <= ictl;
      for (int i = 1; i < 4; i++) begin
        ctl[i] <= ctl[i-1];
      end
      // stage 1
      dat_re  <= llr_demap_pkg::widen(idat.re);
      dat_im  <= llr_demap_pkg::widen(idat.im);
      adat_re <= llr_demap_pkg::abs_wide(llr_demap_pkg::widen(idat.re));
      adat_im <= llr_demap_pkg::abs_wide(llr_demap_pkg::widen(idat.im));
      // stage 2
      // bit 1 of the code picks the b0 form
      b2_met <= dat_im;
      b1_met <= dat_re;
      b0_met <= ctl[0].qam[1] ? (adat_re - adat_im) : (dat_re + dat_im);
      // stage 3
      // psk never carries b3
      sat_llr.b3 <= '0;
      sat_llr.b2 <= llr_demap_pkg::saturate_llr(b2_met);
      sat_llr.b1 <= llr_demap_pkg::saturate_llr(b1_met);
      sat_llr.b0 <= llr_demap_pkg::saturate_llr(b0_met);
      // stage 4
      dly_llr <= sat_llr;
      // stage 5, hold the last valid result
      if (val[3]) begin
        octl <= ctl[3];
        ollr <= dly_llr;
      end
    end
  end

endmodule

// ==== hdl/llr_mode_regs.sv ====
`timescale 1ns/100ps

module llr_mode_regs (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      iclkena,
  input  logic                      cfg_write,
  input  llr_demap_pkg::qam_code_t  cfg_qam,
  input  logic                      ival,
  input  logic                      isop,
  output llr_demap_pkg::stage_ctl_t ctl
);

  // ----------------------------------------------------------
  // code registers
  // ----------------------------------------------------------

  llr_demap_pkg::qam_code_t staged_qam;
  llr_demap_pkg::qam_code_t active_qam;
  llr_demap_pkg::qam_code_t wr_qam;
  logic                     frame_start;

  // unknown codes collapse to bpsk on write
  always_comb begin
    case (cfg_qam)
      llr_demap_pkg::qam_bpsk,
      llr_demap_pkg::qam_qpsk,
      llr_demap_pkg::qam_8psk,
      llr_demap_pkg::qam_qam16: wr_qam = cfg_qam;
      default:                  wr_qam = llr_demap_pkg::qam_bpsk;
    endcase
  end

  assign frame_start = ival & isop;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      staged_qam <= llr_demap_pkg::qam_bpsk;
      active_qam <= llr_demap_pkg::qam_bpsk;
    end else if (iclkena) begin
      if (cfg_write) begin
        staged_qam <= wr_qam;
      end
      // switch over only on a real frame start
      if (frame_start) begin
        active_qam <= staged_qam;
      end
    end
  end

  // ----------------------------------------------------------
  // control for the current sample
  // ----------------------------------------------------------

  // sop sample already sees the staged code
  always_comb begin
    ctl.sop = isop;
    ctl.qam = frame_start ? staged_qam : active_qam;
  end

endmodule

// ==== hdl/llr_demap_pkg.sv ====
`include "llr_demap_settings.svh"

package llr_demap_pkg;

  // ----------------------------------------------------------
  // modulation codes
  // ----------------------------------------------------------

  typedef logic [3:0] qam_code_t;

  localparam qam_code_t qam_bpsk  = 4'd1;
  localparam qam_code_t qam_qpsk  = 4'd2;
  localparam qam_code_t qam_8psk  = 4'd3;
  localparam qam_code_t qam_qam16 = 4'd4;

  // ----------------------------------------------------------
  // data types
  // ----------------------------------------------------------

  typedef logic signed [`LLR_DAT_W-1:0] dat_t;
  // one growth bit over the sample, for sums and magnitudes
  typedef logic signed [`LLR_DAT_W:0]   wide_t;
  typedef logic signed [`LLR_LLR_W-1:0] llr_t;

  typedef struct packed {
    dat_t re;
    dat_t im;
  } sample_t;

  // b0 is the least significant coded bit
  typedef struct packed {
    llr_t b3;
    llr_t b2;
    llr_t b1;
    llr_t b0;
  } llr_word_t;

  // rides along the data pipelines
  typedef struct packed {
    logic      sop;
    qam_code_t qam;
  } stage_ctl_t;

  // clip limits in the widened domain
  localparam wide_t llr_max_w = wide_t'(2**(`LLR_LLR_W-1) - 1);
  localparam wide_t llr_min_w = -wide_t'(2**(`LLR_LLR_W-1));

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------

  // sign extend one component
  function automatic wide_t widen(input dat_t d);
    return wide_t'(d);
  endfunction

  // magnitude, -max fits thanks to the growth bit
  function automatic wide_t abs_wide(input wide_t d);
    return (d < 0) ? -d : d;
  endfunction

  function automatic llr_t saturate_llr(input wide_t dat);
    if (dat > llr_max_w) begin
      return llr_t'(llr_max_w);
    end
    if (dat < llr_min_w) begin
      return llr_t'(llr_min_w);
    end
    return llr_t'(dat);
  endfunction

endpackage

// ==== hdl/llr_demap_settings.svh ====
`ifndef LLR_DEMAP_SETTINGS_SVH
`define LLR_DEMAP_SETTINGS_SVH

// ----------------------------------------------------------
// sample and llr widths
// ----------------------------------------------------------

// one re or im component of the input sample
// keep at llr width + 4 so sums fit before clipping
`define LLR_DAT_W 8

// one soft bit
`define LLR_LLR_W 4

// ----------------------------------------------------------
// 16qam decision geometry
// ----------------------------------------------------------

// inner/outer amplitude boundary in sample units
`define LLR_QAM16_THR 4

`endif
